/* hw/cpu_pkg.sv */
package cpu_pkg;

	// Top nibble of every instruction word
	typedef enum logic [3:0] {
		op_add = 4'h0, op_sub = 4'h1, op_xor = 4'h2, op_red = 4'h3,
		op_sll = 4'h4, op_sra = 4'h5, op_ror = 4'h6, op_paddsb = 4'h7,
		op_lw = 4'h8, op_sw = 4'h9, op_llb = 4'ha, op_lhb = 4'hb,
		op_b = 4'hc, op_br = 4'hd, op_pcs = 4'he, op_hlt = 4'hf
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_xor = 4'd2,
		alu_sll = 4'd4,
		alu_sra = 4'd5,
		alu_ror = 4'd6,
		alu_addr = 4'd10, // Address add, flags untouched
		alu_llb = 4'd11,
		alu_lhb = 4'd12,
		alu_pass = 4'd13  // Source 1 straight through
	} alu_op_e;

	typedef enum logic [2:0] {
		cond_ne = 3'd0, cond_eq = 3'd1, cond_gt = 3'd2, cond_lt = 3'd3,
		cond_ge = 3'd4, cond_le = 3'd5, cond_ov = 3'd6, cond_always = 3'd7
	} cond_e;

	typedef struct packed {
		opcode_e opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;   // Also the 4-bit immediate
	} r_fmt_t;

	typedef struct packed {
		opcode_e opcode;
		logic [3:0] rd;
		logic [7:0] imm8;
	} i_fmt_t;

	typedef struct packed {
		opcode_e opcode;
		cond_e cond;
		logic [8:0] imm9;
	} b_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		b_fmt_t b_fmt;
	} instr_u;

	// APB byte offsets
	localparam logic [7:0] reg_ctrl_addr = 8'h00;
	localparam logic [7:0] reg_status_addr = 8'h04;
	localparam logic [7:0] reg_imem_addr = 8'h08;
	localparam logic [7:0] reg_peek_addr = 8'h0c;

endpackage

/* hw/ctrl_if.sv */
`timescale 1ns/1ns

interface ctrl_if #(
	parameter int data_width = 16
);
	logic valid;
	logic [3:0] rd;
	logic [data_width-1:0] rs_data;
	logic [data_width-1:0] rt_data;
	logic [data_width-1:0] imm;
	logic [data_width-1:0] pc_plus2;
	cpu_pkg::alu_op_e alu_op;
	logic alu_src1;        // 0 rs, 1 pc+2
	logic alu_src2;        // 0 rt, 1 imm
	logic mem_read_en;
	logic mem_write_en;
	logic reg_write_en;
	logic reg_write_src;   // 0 ALU, 1 memory
	logic branch;
	cpu_pkg::cond_e branch_cond;
	logic halt;
	logic illegal;

	modport dec (
		output valid, rd, rs_data, rt_data, imm, pc_plus2, alu_op, alu_src1, alu_src2,
		output mem_read_en, mem_write_en, reg_write_en, reg_write_src,
		output branch, branch_cond, halt, illegal
	);

	modport exe (
		input valid, rd, rs_data, rt_data, imm, pc_plus2, alu_op, alu_src1, alu_src2,
		input mem_read_en, mem_write_en, reg_write_en, reg_write_src,
		input branch, branch_cond, halt, illegal
	);
endinterface

/* hw/apb_regs.sv */
`timescale 1ns/1ns

module apb_regs #(
	parameter int imem_depth = 256,
	parameter int data_width = 16
) (
	input logic clk,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic run,
	output logic imem_we,
	output logic [$clog2(imem_depth)-1:0] imem_waddr,
	output logic [15:0] imem_wdata,
	output logic [3:0] peek_idx,
	input logic [data_width-1:0] peek_data,
	input logic [15:0] pc,
	input logic halted,
	input logic error
);
	localparam int aw = $clog2(imem_depth);

	logic setup;
	logic access;
	logic bad_access;
	logic wr_commit;
	logic start_pend;   // Run comes back one cycle after a CTRL write

	assign setup = psel && !penable;
	assign access = psel && penable;

	always_comb begin
		bad_access = !(paddr inside {cpu_pkg::reg_ctrl_addr, cpu_pkg::reg_status_addr,
			cpu_pkg::reg_imem_addr, cpu_pkg::reg_peek_addr});
		if (pwrite && paddr == cpu_pkg::reg_imem_addr && run)
			bad_access = 1'b1;   // Program memory is locked while running
	end

	// Error was settled in the setup phase
	assign wr_commit = access && pwrite && !pslverr;

	assign imem_we = wr_commit && paddr == cpu_pkg::reg_imem_addr;
	assign imem_waddr = pwdata[16+aw-1:16];
	assign imem_wdata = pwdata[15:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pready <= 1'b0;
			pslverr <= 1'b0;
			run <= 1'b0;
			start_pend <= 1'b0;
			peek_idx <= 4'd0;
		end else begin
			pready <= setup;
			pslverr <= setup && bad_access;
			if (start_pend) begin
				run <= 1'b1;
				start_pend <= 1'b0;
			end
			// A low cycle on run clears halt state and rewinds the pc
			if (wr_commit && paddr == cpu_pkg::reg_ctrl_addr) begin
				run <= 1'b0;
				start_pend <= pwdata[0];
			end
			if (wr_commit && paddr == cpu_pkg::reg_peek_addr)
				peek_idx <= pwdata[3:0];
		end
	end

	always_comb begin
		case (paddr)
			cpu_pkg::reg_ctrl_addr: prdata = {31'd0, run};
			cpu_pkg::reg_status_addr: prdata = {pc, 14'd0, error, halted};
			cpu_pkg::reg_peek_addr: prdata = {{(32-data_width){1'b0}}, peek_data};
			default: prdata = 32'd0;
		endcase
	end

	a_no_wait: assert property (@(posedge clk) disable iff (!arst_n)
		psel && penable |-> pready);
	a_imem_locked: assert property (@(posedge clk) disable iff (!arst_n)
		imem_we |-> !run);

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit #(
	parameter int imem_depth = 256
) (
	input logic clk,
	input logic arst_n,
	input logic run,
	input logic halted,
	input logic imem_we,
	input logic [$clog2(imem_depth)-1:0] imem_waddr,
	input logic [15:0] imem_wdata,
	input logic redirect,
	input logic [15:0] target,
	output logic issue,
	output logic [15:0] instr,
	output logic [15:0] pc_plus2,
	output logic [15:0] pc
);
	localparam int aw = $clog2(imem_depth);

	logic [15:0] imem [imem_depth];
	logic wait_q;   // Execute phase of the current instruction

	assign issue = run && !halted && !wait_q;
	assign instr = imem[pc[aw:1]];   // Word addressed
	assign pc_plus2 = pc + 16'd2;

	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_waddr] <= imem_wdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= 16'd0;
			wait_q <= 1'b0;
		end else if (!run) begin
			pc <= 16'd0;
			wait_q <= 1'b0;
		end else if (wait_q) begin
			wait_q <= 1'b0;
			pc <= redirect ? target : pc_plus2;
		end else if (issue) begin
			wait_q <= 1'b1;
		end
	end

	a_redirect_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
		redirect |-> wait_q);

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage #(
	parameter int data_width = 16
) (
	input logic clk,
	input logic arst_n,
	input logic issue,
	input logic [15:0] instruction,
	input logic [data_width-1:0] f_pc_plus2,
	output logic [3:0] rs_idx,
	output logic [3:0] rt_idx,
	input logic [data_width-1:0] rs_rdata,
	input logic [data_width-1:0] rt_rdata,
	ctrl_if.dec ctrl
);
	cpu_pkg::instr_u instr_q;
	logic [data_width-1:0] pc_plus2_q;
	logic valid_q;
	logic [data_width-1:0] shift_imm;
	logic [data_width-1:0] mem_imm;
	logic [data_width-1:0] byte_imm;
	logic [data_width-1:0] br_imm;

	always_ff @(posedge clk) begin
		if (issue) begin
			instr_q <= instruction;
			pc_plus2_q <= f_pc_plus2;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= issue;
	end

	assign shift_imm = {{(data_width-4){instr_q.r_fmt.rt[3]}}, instr_q.r_fmt.rt};
	assign mem_imm = {{(data_width-5){instr_q.r_fmt.rt[3]}}, instr_q.r_fmt.rt, 1'b0};
	assign byte_imm = {{(data_width-8){1'b0}}, instr_q.i_fmt.imm8};
	assign br_imm = {{(data_width-10){instr_q.b_fmt.imm9[8]}}, instr_q.b_fmt.imm9, 1'b0};

	assign ctrl.valid = valid_q;
	assign ctrl.rd = instr_q.r_fmt.rd;
	assign ctrl.rs_data = rs_rdata;
	assign ctrl.rt_data = rt_rdata;
	assign ctrl.pc_plus2 = pc_plus2_q;
	assign ctrl.branch_cond = instr_q.b_fmt.cond;

	always_comb begin
		rs_idx = instr_q.r_fmt.rs;
		rt_idx = instr_q.r_fmt.rt;
		ctrl.imm = shift_imm;
		ctrl.alu_op = cpu_pkg::alu_pass;
		ctrl.alu_src1 = 1'b0;
		ctrl.alu_src2 = 1'b0;
		ctrl.mem_read_en = 1'b0;
		ctrl.mem_write_en = 1'b0;
		ctrl.reg_write_en = 1'b0;
		ctrl.reg_write_src = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.halt = 1'b0;
		ctrl.illegal = 1'b0;
		case (instr_q.r_fmt.opcode)
			cpu_pkg::op_add: begin
				ctrl.alu_op = cpu_pkg::alu_add;
				ctrl.reg_write_en = 1'b1;
			end
			cpu_pkg::op_sub: begin
				ctrl.alu_op = cpu_pkg::alu_sub;
				ctrl.reg_write_en = 1'b1;
			end
			cpu_pkg::op_xor: begin
				ctrl.alu_op = cpu_pkg::alu_xor;
				ctrl.reg_write_en = 1'b1;
			end
			cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror: begin
				ctrl.alu_op = (instr_q.r_fmt.opcode == cpu_pkg::op_sll) ? cpu_pkg::alu_sll :
					(instr_q.r_fmt.opcode == cpu_pkg::op_sra) ? cpu_pkg::alu_sra :
					cpu_pkg::alu_ror;
				ctrl.alu_src2 = 1'b1;
				ctrl.reg_write_en = 1'b1;
			end
			cpu_pkg::op_lw: begin
				ctrl.alu_op = cpu_pkg::alu_addr;
				ctrl.alu_src2 = 1'b1;
				ctrl.imm = mem_imm;
				ctrl.mem_read_en = 1'b1;
				ctrl.reg_write_en = 1'b1;
				ctrl.reg_write_src = 1'b1;
			end
			cpu_pkg::op_sw: begin
				rt_idx = instr_q.r_fmt.rd;   // Store data comes from bits 11:8
				ctrl.alu_op = cpu_pkg::alu_addr;
				ctrl.alu_src2 = 1'b1;
				ctrl.imm = mem_imm;
				ctrl.mem_write_en = 1'b1;
			end
			cpu_pkg::op_llb, cpu_pkg::op_lhb: begin
				rs_idx = instr_q.i_fmt.rd;   // Read-modify-write of rd
				ctrl.alu_op = (instr_q.r_fmt.opcode == cpu_pkg::op_llb) ?
					cpu_pkg::alu_llb : cpu_pkg::alu_lhb;
				ctrl.alu_src2 = 1'b1;
				ctrl.imm = byte_imm;
				ctrl.reg_write_en = 1'b1;
			end
			cpu_pkg::op_b: begin
				ctrl.alu_op = cpu_pkg::alu_addr;
				ctrl.alu_src1 = 1'b1;
				ctrl.alu_src2 = 1'b1;
				ctrl.imm = br_imm;
				ctrl.branch = 1'b1;
			end
			cpu_pkg::op_br: ctrl.branch = 1'b1;   // Target is rs
			cpu_pkg::op_pcs: begin
				ctrl.alu_src1 = 1'b1;
				ctrl.reg_write_en = 1'b1;
			end
			cpu_pkg::op_hlt: ctrl.halt = 1'b1;
			default: ctrl.illegal = 1'b1;   // RED and PADDSB
		endcase
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
		ctrl.valid |-> !issue);

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit #(
	parameter int dmem_depth = 256,
	parameter int data_width = 16
) (
	input logic clk,
	input logic arst_n,
	input logic run,
	ctrl_if.exe ctrl,
	output logic we,
	output logic [3:0] waddr,
	output logic [data_width-1:0] wdata,
	output logic redirect,
	output logic [data_width-1:0] target,
	output logic halted,
	output logic error
);
	localparam int aw = $clog2(dmem_depth);
	localparam int msb = data_width - 1;
	localparam logic [data_width-1:0] max_pos = {1'b0, {(data_width-1){1'b1}}};
	localparam logic [data_width-1:0] max_neg = {1'b1, {(data_width-1){1'b0}}};

	logic [data_width-1:0] dmem [dmem_depth];
	logic [data_width-1:0] src1, src2, sum, diff, alu_res, mem_rdata;
	logic [2*data_width-1:0] rot;
	logic [3:0] shamt;
	logic ovf_add, ovf_sub, set_z, set_nv, taken;
	logic flag_z, flag_n, flag_v;

	assign src1 = ctrl.alu_src1 ? ctrl.pc_plus2 : ctrl.rs_data;
	assign src2 = ctrl.alu_src2 ? ctrl.imm : ctrl.rt_data;
	assign shamt = ctrl.imm[3:0];
	assign sum = src1 + src2;
	assign diff = src1 - src2;
	assign ovf_add = (src1[msb] == src2[msb]) && (sum[msb] != src1[msb]);
	assign ovf_sub = (src1[msb] != src2[msb]) && (diff[msb] != src1[msb]);
	assign rot = {src1, src1} >> shamt;

	always_comb begin
		case (ctrl.alu_op)
			cpu_pkg::alu_add: alu_res = ovf_add ? (src1[msb] ? max_neg : max_pos) : sum;
			cpu_pkg::alu_sub: alu_res = ovf_sub ? (src1[msb] ? max_neg : max_pos) : diff;
			cpu_pkg::alu_xor: alu_res = src1 ^ src2;
			cpu_pkg::alu_sll: alu_res = src1 << shamt;
			cpu_pkg::alu_sra: alu_res = $signed(src1) >>> shamt;
			cpu_pkg::alu_ror: alu_res = rot[data_width-1:0];
			cpu_pkg::alu_addr: alu_res = sum;
			cpu_pkg::alu_llb: alu_res = {src1[msb:8], src2[7:0]};
			cpu_pkg::alu_lhb: alu_res = {src2[data_width-9:0], src1[7:0]};
			default: alu_res = src1;
		endcase
	end

	assign set_z = ctrl.valid && ctrl.alu_op inside {cpu_pkg::alu_add, cpu_pkg::alu_sub,
		cpu_pkg::alu_xor, cpu_pkg::alu_sll, cpu_pkg::alu_sra, cpu_pkg::alu_ror};
	assign set_nv = ctrl.valid && ctrl.alu_op inside {cpu_pkg::alu_add, cpu_pkg::alu_sub};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			flag_v <= 1'b0;
		end else begin
			if (set_z)
				flag_z <= (alu_res == '0);
			if (set_nv) begin
				flag_n <= alu_res[msb];
				flag_v <= (ctrl.alu_op == cpu_pkg::alu_add) ? ovf_add : ovf_sub;
			end
		end
	end

	always_comb begin
		case (ctrl.branch_cond)
			cpu_pkg::cond_ne: taken = !flag_z;
			cpu_pkg::cond_eq: taken = flag_z;
			cpu_pkg::cond_gt: taken = !flag_z && !flag_n;
			cpu_pkg::cond_lt: taken = flag_n;
			cpu_pkg::cond_ge: taken = flag_z || !flag_n;
			cpu_pkg::cond_le: taken = flag_z || flag_n;
			cpu_pkg::cond_ov: taken = flag_v;
			default: taken = 1'b1;
		endcase
	end

	assign redirect = ctrl.valid && ctrl.branch && taken;
	assign target = alu_res;   // pc+2+imm for B, rs for BR

	// Byte address, word storage
	assign mem_rdata = ctrl.mem_read_en ? dmem[alu_res[aw:1]] : '0;

	always_ff @(posedge clk) begin
		if (ctrl.valid && ctrl.mem_write_en)
			dmem[alu_res[aw:1]] <= ctrl.rt_data;
	end

	assign we = ctrl.valid && ctrl.reg_write_en && ctrl.rd != 4'd0;
	assign waddr = ctrl.rd;
	assign wdata = ctrl.reg_write_src ? mem_rdata : alu_res;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			halted <= 1'b0;
			error <= 1'b0;
		end else if (!run) begin
			halted <= 1'b0;   // Restart
			error <= 1'b0;
		end else if (ctrl.valid && (ctrl.halt || ctrl.illegal)) begin
			halted <= 1'b1;
			error <= ctrl.illegal;
		end
	end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ns

module reg_file #(
	parameter int data_width = 16
) (
	input logic clk,
	input logic arst_n,
	input logic [3:0] rs_idx,
	input logic [3:0] rt_idx,
	output logic [data_width-1:0] rs_rdata,
	output logic [data_width-1:0] rt_rdata,
	input logic we,
	input logic [3:0] waddr,
	input logic [data_width-1:0] wdata,
	input logic [3:0] peek_idx,
	output logic [data_width-1:0] peek_data
);
	logic [data_width-1:0] regs [16];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (we && waddr != 4'd0) begin
			regs[waddr] <= wdata;   // R0 never written, so reads zero
		end
	end

	assign rs_rdata = regs[rs_idx];
	assign rt_rdata = regs[rt_idx];
	assign peek_data = regs[peek_idx];

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
	parameter int imem_depth = 256,
	parameter int dmem_depth = 256,
	parameter int data_width = 16
) (
	input logic clk,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic halted
);
	logic run, imem_we, issue, redirect, we, error;
	logic [$clog2(imem_depth)-1:0] imem_waddr;
	logic [15:0] imem_wdata, instr, pc_plus2, pc, target;
	logic [3:0] peek_idx, rs_idx, rt_idx, waddr;
	logic [data_width-1:0] peek_data, rs_rdata, rt_rdata, wdata;

	ctrl_if #(.data_width(data_width)) u_ctrl ();

	apb_regs #(.imem_depth(imem_depth), .data_width(data_width)) u_apb_regs (
		.clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .run,
		.imem_we, .imem_waddr, .imem_wdata,
		.peek_idx, .peek_data, .pc, .halted, .error
	);

	fetch_unit #(.imem_depth(imem_depth)) u_fetch (
		.clk, .arst_n, .run, .halted,
		.imem_we, .imem_waddr, .imem_wdata,
		.redirect, .target, .issue, .instr, .pc_plus2, .pc
	);

	decode_stage #(.data_width(data_width)) u_decode (
		.clk, .arst_n, .issue,
		.instruction(instr),
		.f_pc_plus2(pc_plus2),
		.rs_idx, .rt_idx, .rs_rdata, .rt_rdata,
		.ctrl(u_ctrl.dec)
	);

	exec_unit #(.dmem_depth(dmem_depth), .data_width(data_width)) u_exec (
		.clk, .arst_n, .run,
		.ctrl(u_ctrl.exe),
		.we, .waddr, .wdata, .redirect, .target, .halted, .error
	);

	reg_file #(.data_width(data_width)) u_reg_file (
		.clk, .arst_n, .rs_idx, .rt_idx, .rs_rdata, .rt_rdata,
		.we, .waddr, .wdata, .peek_idx, .peek_data
	);

endmodule

/* test/tb_cases.svh */
localparam int n_progs = 5;
localparam int n_words = 55;
localparam int n_checks = 25;

typedef struct {
	string name;
	int prog;            // Program that sets this register
	int ridx;
	logic [31:0] value;
} reg_check_t;

function automatic logic [15:0] r_word(cpu_pkg::opcode_e op, int rd, int rs, int rt);
	cpu_pkg::instr_u w;
	w.r_fmt.opcode = op;
	w.r_fmt.rd = rd[3:0];
	w.r_fmt.rs = rs[3:0];
	w.r_fmt.rt = rt[3:0];   // Shift amount or word offset for LW and SW
	return w;
endfunction

function automatic logic [15:0] i_word(cpu_pkg::opcode_e op, int rd, int imm);
	cpu_pkg::instr_u w;
	w.i_fmt.opcode = op;
	w.i_fmt.rd = rd[3:0];
	w.i_fmt.imm8 = imm[7:0];
	return w;
endfunction

function automatic logic [15:0] b_word(cpu_pkg::opcode_e op, cpu_pkg::cond_e c, int imm);
	cpu_pkg::instr_u w;
	w.b_fmt.opcode = op;
	w.b_fmt.cond = c;
	w.b_fmt.imm9 = imm[8:0];   // Word offset for B, rs in bits 7:4 for BR
	return w;
endfunction

string prog_names [n_progs] = '{"arith", "shift", "memory", "branch", "illegal"};
int prog_len [n_progs] = '{16, 10, 11, 13, 5};
int prog_status [n_progs] = '{1, 1, 1, 1, 3};   // Error in bit 1, halted in bit 0

logic [15:0] prog_words [n_words] = '{
	// Constants, saturating add and sub, xor
	i_word(cpu_pkg::op_llb, 1, 'h34), i_word(cpu_pkg::op_lhb, 1, 'h12),
	i_word(cpu_pkg::op_llb, 2, 'hff), i_word(cpu_pkg::op_lhb, 2, 'h7f),
	i_word(cpu_pkg::op_llb, 3, 'h01), r_word(cpu_pkg::op_add, 4, 1, 3),
	r_word(cpu_pkg::op_add, 5, 2, 3), i_word(cpu_pkg::op_llb, 6, 'h00),
	i_word(cpu_pkg::op_lhb, 6, 'h80), r_word(cpu_pkg::op_sub, 7, 6, 3),
	r_word(cpu_pkg::op_sub, 8, 1, 3), r_word(cpu_pkg::op_xor, 9, 1, 2),
	r_word(cpu_pkg::op_add, 10, 6, 6), r_word(cpu_pkg::op_sub, 11, 3, 1),
	r_word(cpu_pkg::op_add, 0, 1, 1), r_word(cpu_pkg::op_hlt, 0, 0, 0),
	// Shifts of 0x8421
	i_word(cpu_pkg::op_llb, 1, 'h21), i_word(cpu_pkg::op_lhb, 1, 'h84),
	r_word(cpu_pkg::op_sll, 2, 1, 4), r_word(cpu_pkg::op_sra, 3, 1, 4),
	r_word(cpu_pkg::op_ror, 4, 1, 4), r_word(cpu_pkg::op_sll, 5, 1, 15),
	r_word(cpu_pkg::op_sra, 6, 1, 15), r_word(cpu_pkg::op_ror, 7, 1, 8),
	r_word(cpu_pkg::op_ror, 9, 1, 1), r_word(cpu_pkg::op_hlt, 0, 0, 0),
	// Stores at 0x46 and 0x3c, loads back through another base
	i_word(cpu_pkg::op_llb, 1, 'h40), i_word(cpu_pkg::op_lhb, 1, 'h00),
	i_word(cpu_pkg::op_llb, 2, 'hcd), i_word(cpu_pkg::op_lhb, 2, 'hab),
	r_word(cpu_pkg::op_sw, 2, 1, 3), r_word(cpu_pkg::op_sw, 1, 1, -2),
	i_word(cpu_pkg::op_llb, 3, 'h4a), i_word(cpu_pkg::op_lhb, 3, 'h00),
	r_word(cpu_pkg::op_lw, 4, 3, -2), r_word(cpu_pkg::op_lw, 5, 3, -7),
	r_word(cpu_pkg::op_hlt, 0, 0, 0),
	// Taken B, not-taken B, BR to pc 0x16, PCS there
	r_word(cpu_pkg::op_xor, 4, 4, 4), r_word(cpu_pkg::op_xor, 5, 5, 5),
	r_word(cpu_pkg::op_sub, 3, 1, 1), b_word(cpu_pkg::op_b, cpu_pkg::cond_eq, 1),
	i_word(cpu_pkg::op_llb, 4, 'hee), b_word(cpu_pkg::op_b, cpu_pkg::cond_ne, 1),
	i_word(cpu_pkg::op_llb, 5, 'h77), i_word(cpu_pkg::op_llb, 6, 'h16),
	i_word(cpu_pkg::op_lhb, 6, 'h00), b_word(cpu_pkg::op_br, cpu_pkg::cond_always, 'h60),
	i_word(cpu_pkg::op_llb, 4, 'h55), r_word(cpu_pkg::op_pcs, 7, 0, 0),
	r_word(cpu_pkg::op_hlt, 0, 0, 0),
	// RED stops the core before the second LLB
	r_word(cpu_pkg::op_xor, 8, 8, 8), i_word(cpu_pkg::op_llb, 8, 'h11),
	r_word(cpu_pkg::op_red, 9, 1, 1), i_word(cpu_pkg::op_llb, 8, 'h99),
	r_word(cpu_pkg::op_hlt, 0, 0, 0)
};

reg_check_t reg_checks [n_checks] = '{
	'{"arith r0 stays zero", 0, 0, 'h0000}, '{"arith llb lhb r1", 0, 1, 'h1234},
	'{"arith llb lhb r2", 0, 2, 'h7fff}, '{"arith add r4", 0, 4, 'h1235},
	'{"arith add sat pos r5", 0, 5, 'h7fff}, '{"arith lhb r6", 0, 6, 'h8000},
	'{"arith sub sat neg r7", 0, 7, 'h8000}, '{"arith sub r8", 0, 8, 'h1233},
	'{"arith xor r9", 0, 9, 'h6dcb}, '{"arith add sat neg r10", 0, 10, 'h8000},
	'{"arith sub neg r11", 0, 11, 'hedcd},
	'{"shift sll 4", 1, 2, 'h4210}, '{"shift sra 4", 1, 3, 'hf842},
	'{"shift ror 4", 1, 4, 'h1842}, '{"shift sll 15", 1, 5, 'h8000},
	'{"shift sra 15", 1, 6, 'hffff}, '{"shift ror 8", 1, 7, 'h2184},
	'{"shift ror 1", 1, 9, 'hc210},
	'{"memory lw r4", 2, 4, 'habcd}, '{"memory lw r5", 2, 5, 'h0040},
	'{"branch sub zero r3", 3, 3, 'h0000}, '{"branch taken skip r4", 3, 4, 'h0000},
	'{"branch not taken r5", 3, 5, 'h0077}, '{"branch br pcs r7", 3, 7, 'h0018},
	'{"illegal stops core r8", 4, 8, 'h0011}
};

/* test/tb_top.sv */
`timescale 1ns/1ns

module tb_top;
	logic clk;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic halted;

	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;

	`include "tb_cases.svh"

	localparam int cycle_limit = 64 * n_words + 2000;

	cpu_top #(.imem_depth(256), .dmem_depth(256), .data_width(16)) u_cpu_top (
		.clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .halted
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: no result after %0d cycles", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
			fail_count++;
		end else begin
			$display("pass %s: 0x%h", name, actual);
			pass_count++;
		end
	endtask

	task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);   // Access phase, outputs settled
		while (!pready && waits < 8) begin
			@(negedge clk);
			waits++;
		end
		if (!pready) begin
			$display("APB access to offset 0x%h never completed", addr);
			fail_count++;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_access(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic peek_reg(input logic [3:0] idx, output logic [31:0] value);
		logic wr_err;
		logic rd_err;
		apb_write(cpu_pkg::reg_peek_addr, {28'd0, idx}, wr_err);
		apb_read(cpu_pkg::reg_peek_addr, value, rd_err);
		if (wr_err || rd_err) begin
			$display("PEEK access for r%0d was answered with pslverr", idx);
			fail_count++;
		end
	endtask

	// Stop, load the words, start at pc 0 and wait for the halt
	task automatic run_program(input int p, input int first);
		logic err;
		logic load_err;
		load_err = 1'b0;
		apb_write(cpu_pkg::reg_ctrl_addr, 32'd0, err);
		for (int k = 0; k < prog_len[p]; k++) begin
			apb_write(cpu_pkg::reg_imem_addr, {8'd0, 8'(k), prog_words[first + k]}, err);
			load_err |= err;
		end
		if (load_err) begin
			$display("program %s: an instruction load was rejected", prog_names[p]);
			fail_count++;
		end
		apb_write(cpu_pkg::reg_ctrl_addr, 32'd1, err);
		while (!halted)
			@(negedge clk);
	endtask

	initial begin
		logic [31:0] rd_data;
		logic rd_err;
		int first;
		clk = 1'b0;
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'd0;
		pwdata = 32'd0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		apb_read(cpu_pkg::reg_status_addr, rd_data, rd_err);
		check_value("reset status", 32'd0, rd_data);
		for (int r = 0; r < 16; r++) begin
			peek_reg(4'(r), rd_data);
			check_value($sformatf("reset r%0d", r), 32'd0, rd_data);
		end

		first = 0;
		for (int p = 0; p < n_progs; p++) begin
			run_program(p, first);
			apb_read(cpu_pkg::reg_status_addr, rd_data, rd_err);
			check_value($sformatf("%s status", prog_names[p]), prog_status[p], rd_data & 32'h3);
			for (int c = 0; c < n_checks; c++) begin
				if (reg_checks[c].prog == p) begin
					peek_reg(4'(reg_checks[c].ridx), rd_data);
					check_value(reg_checks[c].name, reg_checks[c].value, rd_data);
				end
			end
			first += prog_len[p];
		end

		// Core is halted but run is still set
		apb_write(cpu_pkg::reg_imem_addr, 32'h0000_0000, rd_err);
		check_value("imem write while running", 32'd1, {31'd0, rd_err});
		apb_read(8'h10, rd_data, rd_err);
		check_value("unknown offset", 32'd1, {31'd0, rd_err});

		$display("checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* all.f */
+incdir+test
hw/cpu_pkg.sv
hw/ctrl_if.sv
hw/apb_regs.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/exec_unit.sv
hw/reg_file.sv
hw/cpu_top.sv
test/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f all.f -Mdir obj_dir -o tb_top_sim
./obj_dir/tb_top_sim | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
